//--- run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module front_end_tb \
    -o front_end_sim

./obj_dir/front_end_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    exit 1
fi
exit 0

//--- test/front_end_properties.sv
`timescale 1ns/1ps

module front_end_properties import fetch_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        bubble,
    input logic        be_hold,
    input stall_vec_t  stall,
    input fetch_slot_t slot
);

    // a taken jal leaves an empty if_id behind it
    flush_clears_slot: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !slot.valid
    ) else $error("if_id slot valid after flush");

    // full freeze of pc, if_id and decode
    hold_keeps_slot: assert property (
        @(posedge clk) disable iff (reset)
        (stall[2:0] == 3'b111) |=> $stable(slot)
    ) else $error("if_id slot changed while held");

    no_bubble_in_hold: assert property (
        @(posedge clk) disable iff (reset)
        be_hold |-> !bubble
    ) else $error("bubble raised during back end hold");

endmodule

// if_id and stall_ctrl signals as seen from the top level
bind front_end front_end_properties props_i (
    .clk     (clk),
    .reset   (reset),
    .flush   (redirect_valid),
    .bubble  (bubble),
    .be_hold (be_hold),
    .stall   (stall),
    .slot    (id_slot)
);

//--- test/front_end_tb.sv
`timescale 1ns/1ps

`include "front_defs.svh"

module front_end_tb import fetch_pkg::*, decode_pkg::*;;

    localparam int n_inst    = 300;
    localparam int mem_words = 1024;
    localparam int max_cycles = n_inst * 12 + 40;  // worst case per instruction plus reset

    logic                   clk;
    logic                   reset;
    logic [`PC_WIDTH-1:0]   imem_addr;
    logic                   imem_req;
    logic [`INST_WIDTH-1:0] imem_data;
    logic                   imem_valid;
    logic                   be_hold;
    decoded_t               decoded_out;

    logic [31:0] prog [mem_words];
    logic [31:0] lcg_state;
    logic        hold_enable;
    logic        running;
    logic        held_prev;
    decoded_t    last_out;
    logic [`PC_WIDTH-1:0] exp_pc;
    logic        armed;
    int          delay_cnt;
    int          n_done;
    int          n_jal;
    int          n_illegal;
    int          n_hold;
    int          checks;
    int          errors;

    front_end dut_i (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .imem_data   (imem_data),
        .imem_valid  (imem_valid),
        .be_hold     (be_hold),
        .decoded_out (decoded_out)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [`PC_WIDTH-1:0] addr);
        logic [`PC_WIDTH-1:0] offs;
        offs = (addr - `PC_RESET) >> 2;
        return prog[offs[9:0]];
    endfunction

    // expected decode of one word straight from the ISA encoding
    function automatic decoded_t ref_decode(input logic [31:0] w, input logic [63:0] pc);
        decoded_t d;
        d = '0;
        d.valid  = 1'b1;
        d.pc     = pc;
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
        d.funct7 = w[31:25];
        case (w[6:0])
            7'h37:   d.op_class = cls_lui;
            7'h17:   d.op_class = cls_auipc;
            7'h6f:   d.op_class = cls_jal;
            7'h67:   d.op_class = cls_jalr;
            7'h63:   d.op_class = cls_branch;
            7'h03:   d.op_class = cls_load;
            7'h23:   d.op_class = cls_store;
            7'h13:   d.op_class = cls_op_imm;
            7'h33:   d.op_class = cls_op;
            7'h1b:   d.op_class = cls_op_imm_w;
            7'h3b:   d.op_class = cls_op_w;
            7'h73:   d.op_class = cls_system;
            default: d.op_class = cls_illegal;
        endcase
        // immediate by instruction format
        case (w[6:0])
            7'h37, 7'h17: d.imm = 64'($signed({w[31:12], 12'h000}));        // u type
            7'h6f: d.imm = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            7'h63: d.imm = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            7'h23: d.imm = 64'($signed({w[31:25], w[11:7]}));               // s type
            7'h67, 7'h03, 7'h13, 7'h1b, 7'h73: begin
                d.imm = 64'($signed(w[31:20]));                             // i type
            end
            default: d.imm = '0;    // r type and illegal carry none
        endcase
        return d;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic build_program();
        logic [6:0]  opcodes [12];
        logic [31:0] r;
        logic [31:0] body;
        logic [20:0] off;
        opcodes = '{7'h37, 7'h17, 7'h67, 7'h63, 7'h03, 7'h23,
                    7'h13, 7'h33, 7'h1b, 7'h3b, 7'h73, 7'h0b};  // last one is illegal
        for (int i = 0; i < mem_words; i++) begin
            r = next_rand();
            body = next_rand();
            if (r[31:28] == 4'd0) begin
                off = 21'((2 + (next_rand() >> 8) % 8) * 4);   // short forward jump
                prog[i] = {off[20], off[10:1], off[11], off[19:12], body[11:7], 7'h6f};
            end else begin
                prog[i] = {body[31:7], opcodes[(r >> 16) % 12]};
            end
        end
    endtask

    // memory data follows the address, valid is a level after a random wait
    assign imem_data = fetch_word(imem_addr);

    always @(posedge clk) begin
        if (reset) begin
            imem_valid <= 1'b0;
            armed = 1'b0;
        end else if (imem_valid && imem_req && !be_hold) begin
            imem_valid <= 1'b0;     // taken, next address starts a new wait
            armed = 1'b0;
        end else if (imem_req && !imem_valid) begin
            if (!armed) begin
                delay_cnt = int'((next_rand() >> 12) % 4);
                armed = 1'b1;
            end
            if (delay_cnt == 0) begin
                imem_valid <= 1'b1;
            end else begin
                delay_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        if (hold_enable) begin
            be_hold <= ((next_rand() >> 20) % 8) == 0;
        end else begin
            be_hold <= 1'b0;
        end
    end

    // compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        decoded_t exp;
        if (running) begin
            if (held_prev) begin
                n_hold++;
                check("decoded_out.valid (held)", 64'(decoded_out.valid), 64'(last_out.valid));
                check("decoded_out.pc (held)", decoded_out.pc, last_out.pc);
                check("decoded_out.imm (held)", decoded_out.imm, last_out.imm);
            end else if (decoded_out.valid) begin
                exp = ref_decode(fetch_word(exp_pc), exp_pc);
                check("decoded_out.pc", decoded_out.pc, exp.pc);
                check("decoded_out.op_class", 64'(decoded_out.op_class), 64'(exp.op_class));
                check("decoded_out.rd", 64'(decoded_out.rd), 64'(exp.rd));
                check("decoded_out.rs1", 64'(decoded_out.rs1), 64'(exp.rs1));
                check("decoded_out.rs2", 64'(decoded_out.rs2), 64'(exp.rs2));
                check("decoded_out.funct3", 64'(decoded_out.funct3), 64'(exp.funct3));
                check("decoded_out.funct7", 64'(decoded_out.funct7), 64'(exp.funct7));
                check("decoded_out.imm", decoded_out.imm, exp.imm);
                if (exp.op_class == cls_jal) begin
                    n_jal++;
                    exp_pc = exp_pc + exp.imm;
                end else begin
                    exp_pc = exp_pc + 64'(`INST_STEP);
                end
                if (exp.op_class == cls_illegal) n_illegal++;
                n_done++;
            end
            last_out = decoded_out;
            held_prev = be_hold;
        end
    end

    initial begin
        #(max_cycles * 40);
        $display("watchdog expired after %0d cycles, decode stream stalled", max_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int errs_before;
        clk = 1'b0;
        reset = 1'b1;
        be_hold = 1'b0;
        imem_valid = 1'b0;
        hold_enable = 1'b0;
        running = 1'b0;
        held_prev = 1'b0;
        armed = 1'b0;
        delay_cnt = 0;
        lcg_state = 32'd26681;
        n_done = 0;
        n_jal = 0;
        n_illegal = 0;
        n_hold = 0;
        checks = 0;
        errors = 0;
        exp_pc = `PC_RESET;
        build_program();

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        running = 1'b1;
        @(negedge clk);
        check("decoded_out.valid", 64'(decoded_out.valid), 64'd0);
        check("imem_req", 64'(imem_req), 64'd1);
        check("imem_addr", imem_addr, `PC_RESET);
        $display("test reset_state: %0d errors", errors);

        errs_before = errors;
        repeat (3) @(posedge clk);
        hold_enable <= 1'b1;

        wait (n_done >= n_inst);
        running = 1'b0;
        if (n_jal == 0) begin
            errors++;
            $display("no jal reached decode, redirect path not exercised");
        end
        if (n_illegal == 0) begin
            errors++;
            $display("no illegal opcode reached decode");
        end
        if (n_hold == 0) begin
            errors++;
            $display("back end hold never asserted during the stream");
        end
        $display("test decode_stream: %0d inst, %0d jal, %0d illegal, %0d held, %0d errors",
                 n_done, n_jal, n_illegal, n_hold, errors - errs_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/decode_pkg.sv
verilog/pc_fetch.sv
verilog/if_id.sv
verilog/inst_decode.sv
verilog/stall_ctrl.sv
verilog/front_end.sv
test/front_end_properties.sv
test/front_end_tb.sv

//--- verilog/decode_pkg.sv
`include "front_defs.svh"

package decode_pkg;

    // rv64 base opcodes, inst[6:0]
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_op_imm_w = 7'b0011011;
    localparam logic [6:0] opc_op_w     = 7'b0111011;
    localparam logic [6:0] opc_system   = 7'b1110011;

    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_op_imm_w,
        cls_op_w,
        cls_system,
        cls_illegal
    } op_class_t;

    // what the front end hands to the back end
    typedef struct packed {
        logic                 valid;
        logic [`PC_WIDTH-1:0] pc;
        op_class_t            op_class;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [`PC_WIDTH-1:0] imm;    // sign extended to full width
    } decoded_t;

endpackage

//--- verilog/fetch_pkg.sv
`include "front_defs.svh"

package fetch_pkg;

    // per-stage stall bits, set means that stage holds its state
    typedef logic [`STALL_WIDTH-1:0] stall_vec_t;

    localparam int stall_pc   = 0;
    localparam int stall_ifid = 1;
    localparam int stall_dec  = 2;

    // waiting on instruction memory, only the pc stage holds
    localparam stall_vec_t stall_fetch_wait = `STALL_WIDTH'b00001;
    // back end busy, freeze everything up to and including decode
    localparam stall_vec_t stall_be_hold = `STALL_WIDTH'b00111;

    // one fetched instruction on its way to decode
    typedef struct packed {
        logic                   valid;
        logic [`PC_WIDTH-1:0]   pc;
        logic [`INST_WIDTH-1:0] inst;
    } fetch_slot_t;

endpackage

//--- verilog/front_defs.svh
`ifndef FRONT_DEFS_SVH
`define FRONT_DEFS_SVH

// address of the very first fetch after reset
`define PC_RESET 64'h0000_0000_8000_0000

// datapath widths of the front end
`define PC_WIDTH 64
`define INST_WIDTH 32

// sequential pc increment, no compressed instructions
`define INST_STEP 4

// one stall bit per pipeline stage
// bit 0 pc, bit 1 if_id, bit 2 decode
// bits 3 and 4 belong to the back end
`define STALL_WIDTH 5

`endif

//--- verilog/front_end.sv
`timescale 1ns/1ps

`include "front_defs.svh"

module front_end import fetch_pkg::*, decode_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`PC_WIDTH-1:0]   imem_addr,
    output logic                   imem_req,
    input  logic [`INST_WIDTH-1:0] imem_data,
    input  logic                   imem_valid,
    input  logic                   be_hold,
    output decoded_t               decoded_out
);

    stall_vec_t           stall;
    logic                 bubble;
    logic                 redirect_valid;
    logic [`PC_WIDTH-1:0] redirect_pc;
    fetch_slot_t          fetch_slot;
    fetch_slot_t          id_slot;

    pc_fetch pc_fetch_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_valid     (imem_valid),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .imem_req       (imem_req),
        .fetch_slot     (fetch_slot)
    );

    stall_ctrl stall_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_valid (imem_valid),
        .be_hold    (be_hold),
        .stall      (stall),
        .bubble     (bubble)
    );

    // a taken jal flushes the fetch-to-decode register
    if_id if_id_i (
        .clk      (clk),
        .reset    (reset),
        .flush    (redirect_valid),
        .bubble   (bubble),
        .stall    (stall),
        .slot_in  (fetch_slot),
        .slot_out (id_slot)
    );

    inst_decode inst_decode_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .slot           (id_slot),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .decoded_out    (decoded_out)
    );

endmodule

//--- verilog/if_id.sv
`timescale 1ns/1ps

module if_id import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        bubble,
    input  stall_vec_t  stall,
    input  fetch_slot_t slot_in,
    output fetch_slot_t slot_out
);

    logic hold;

    // full front end freeze, pc, if_id and decode all stalled
    assign hold = stall[stall_pc] & stall[stall_ifid] & stall[stall_dec];

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_out <= '0;
        end else if (flush) begin
            // taken jump in decode, drop whatever fetch delivered
            slot_out <= '0;
        end else if (!hold) begin
            if (bubble) begin
                slot_out <= '0;     // fetch still waiting on memory
            end else begin
                slot_out <= slot_in;
            end
        end
    end

endmodule

//--- verilog/inst_decode.sv
`timescale 1ns/1ps

`include "front_defs.svh"

module inst_decode import fetch_pkg::*, decode_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  stall_vec_t           stall,
    input  fetch_slot_t          slot,
    output logic                 redirect_valid,
    output logic [`PC_WIDTH-1:0] redirect_pc,
    output decoded_t             decoded_out
);

    logic [`INST_WIDTH-1:0] inst;
    logic [6:0]             opcode;
    op_class_t              op_class;
    logic [`PC_WIDTH-1:0]   imm_i;
    logic [`PC_WIDTH-1:0]   imm_s;
    logic [`PC_WIDTH-1:0]   imm_b;
    logic [`PC_WIDTH-1:0]   imm_u;
    logic [`PC_WIDTH-1:0]   imm_j;
    logic [`PC_WIDTH-1:0]   imm;
    decoded_t               dec;

    assign inst   = slot.inst;
    assign opcode = inst[6:0];

    // immediate formats, all sign extended from inst[31]
    assign imm_i = {{(`PC_WIDTH-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`PC_WIDTH-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`PC_WIDTH-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {{(`PC_WIDTH-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`PC_WIDTH-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            opc_lui:      op_class = cls_lui;
            opc_auipc:    op_class = cls_auipc;
            opc_jal:      op_class = cls_jal;
            opc_jalr:     op_class = cls_jalr;
            opc_branch:   op_class = cls_branch;
            opc_load:     op_class = cls_load;
            opc_store:    op_class = cls_store;
            opc_op_imm:   op_class = cls_op_imm;
            opc_op:       op_class = cls_op;
            opc_op_imm_w: op_class = cls_op_imm_w;
            opc_op_w:     op_class = cls_op_w;
            opc_system:   op_class = cls_system;
            default:      op_class = cls_illegal;
        endcase
    end

    // pick the format that goes with the class
    always_comb begin
        case (op_class)
            cls_lui, cls_auipc:   imm = imm_u;
            cls_jal:              imm = imm_j;
            cls_branch:           imm = imm_b;
            cls_store:            imm = imm_s;
            cls_jalr, cls_load, cls_op_imm, cls_op_imm_w, cls_system: begin
                imm = imm_i;
            end
            default:              imm = '0;   // register ops and illegal
        endcase
    end

    always_comb begin
        dec.valid    = slot.valid;
        dec.pc       = slot.pc;
        dec.op_class = op_class;
        dec.rd       = inst[11:7];
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.funct3   = inst[14:12];
        dec.funct7   = inst[31:25];
        dec.imm      = imm;
    end

    // jal resolved here, fetch jumps and if_id is flushed at the same edge
    assign redirect_valid = slot.valid & (op_class == cls_jal) & ~stall[stall_dec];
    assign redirect_pc    = slot.pc + imm_j;

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded_out.valid <= 1'b0;
        end else if (!stall[stall_dec]) begin
            decoded_out <= dec;
        end
    end

endmodule

//--- verilog/pc_fetch.sv
`timescale 1ns/1ps

`include "front_defs.svh"

module pc_fetch import fetch_pkg::*, decode_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  stall_vec_t             stall,
    input  logic                   redirect_valid,
    input  logic [`PC_WIDTH-1:0]   redirect_pc,
    input  logic                   imem_valid,
    input  logic [`INST_WIDTH-1:0] imem_data,
    output logic [`PC_WIDTH-1:0]   imem_addr,
    output logic                   imem_req,
    output fetch_slot_t            fetch_slot
);

    logic [`PC_WIDTH-1:0] pc;
    logic                 pending;  // pc holds an address not yet fetched
    logic                 accept;
    logic                 is_jal;

    assign imem_addr = pc;
    assign imem_req  = pending;

    // memory answered and the pc stage is free to move on
    assign accept = pending & imem_valid & ~stall[stall_pc];

    // peek at the opcode so fetch can park behind a jump
    assign is_jal = (imem_data[6:0] == opc_jal);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `PC_RESET;
            pending <= 1'b1;
        end else if (redirect_valid) begin
            // jump target from decode wins over everything
            pc      <= redirect_pc;
            pending <= 1'b1;    // re-arm the request at the target
        end else if (accept) begin
            pc <= pc + `PC_WIDTH'(`INST_STEP);
            // the word after a jal is never used, so stop asking
            // until decode sends the target back
            pending <= ~is_jal;
        end
    end

    // the slot is only valid in the cycle the word is taken
    always_comb begin
        fetch_slot.valid = accept;
        fetch_slot.pc    = pc;
        fetch_slot.inst  = imem_data;
    end

endmodule

//--- verilog/stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl import fetch_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       imem_req,
    input  logic       imem_valid,
    input  logic       be_hold,
    output stall_vec_t stall,
    output logic       bubble
);

    logic started;      // high from the first edge after reset
    logic fetch_wait;

    // requests only count once the front end has left reset
    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // pc has an outstanding address and memory has not answered yet
    assign fetch_wait = started & imem_req & ~imem_valid;

    always_comb begin
        stall  = '0;
        bubble = 1'b0;
        if (started && be_hold) begin
            // back end hold covers any fetch wait as well
            stall = stall_be_hold;
        end else if (fetch_wait) begin
            stall  = stall_fetch_wait;
            bubble = 1'b1;      // decode gets an empty slot meanwhile
        end
    end

endmodule
